/* hdl/ps2_pkg.sv */
package ps2_pkg;

    // One byte of a set-2 scan code stream
    typedef logic [7:0] scan_byte_t;

    // Start, 8 data bits LSB first, odd parity, stop
    localparam int FRAME_BITS = 11;

    // Bit positions inside an assembled frame
    localparam int START_POS  = 0;
    localparam int PARITY_POS = 9;
    localparam int STOP_POS   = 10;

    // Next code is a key release
    localparam scan_byte_t BREAK_PREFIX = 8'hF0;

    // Next code belongs to the extended key block
    localparam scan_byte_t EXT_PREFIX = 8'hE0;

endpackage

/* hdl/key_pkg.sv */
package key_pkg;

    typedef struct packed {
        logic [7:0] ascii;     // Upper case letter or digit or zero
        logic [7:0] scan;      // Final scan code byte
        logic       released;  // Preceded by F0
        logic       extended;  // Preceded by E0
    } key_event_t;

    // Set-2 make code to upper case ASCII
    function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
        logic [7:0] ascii;
        case (code)
            8'h1C: ascii = 8'h41; // A
            8'h32: ascii = 8'h42;
            8'h21: ascii = 8'h43;
            8'h23: ascii = 8'h44;
            8'h24: ascii = 8'h45;
            8'h2B: ascii = 8'h46;
            8'h34: ascii = 8'h47;
            8'h33: ascii = 8'h48;
            8'h43: ascii = 8'h49;
            8'h3B: ascii = 8'h4A;
            8'h42: ascii = 8'h4B;
            8'h4B: ascii = 8'h4C;
            8'h3A: ascii = 8'h4D;
            8'h31: ascii = 8'h4E;
            8'h44: ascii = 8'h4F;
            8'h4D: ascii = 8'h50;
            8'h15: ascii = 8'h51;
            8'h2D: ascii = 8'h52;
            8'h1B: ascii = 8'h53;
            8'h2C: ascii = 8'h54;
            8'h3C: ascii = 8'h55;
            8'h2A: ascii = 8'h56;
            8'h1D: ascii = 8'h57;
            8'h22: ascii = 8'h58;
            8'h35: ascii = 8'h59;
            8'h1A: ascii = 8'h5A; // Z
            8'h45: ascii = 8'h30; // 0
            8'h16: ascii = 8'h31;
            8'h1E: ascii = 8'h32;
            8'h26: ascii = 8'h33;
            8'h25: ascii = 8'h34;
            8'h2E: ascii = 8'h35;
            8'h36: ascii = 8'h36;
            8'h3D: ascii = 8'h37;
            8'h3E: ascii = 8'h38;
            8'h46: ascii = 8'h39; // 9
            default: ascii = 8'h00;
        endcase
        return ascii;
    endfunction

endpackage

/* hdl/ps2_frame_rx.sv */
module ps2_frame_rx import ps2_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       scan_full,
    output logic       byte_valid,
    output scan_byte_t byte_data,
    output logic       overflow,
    output logic       frame_error
);

    localparam int CNT_W = $clog2(FRAME_BITS);

    logic [2:0]            clk_sync;   // ps2_clk synchronizer
    logic [2:0]            data_sync;  // ps2_data synchronizer
    logic                  clk_prev;   // Previous synchronized ps2_clk
    logic                  fall;
    logic [CNT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] frame;
    logic [FRAME_BITS-1:0] next_frame;
    logic                  last_bit;
    logic                  frame_ok;

    // Lines idle high, so the chain resets to 1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[1:0], ps2_data};
            clk_prev  <= clk_sync[2];
        end
    end

    assign fall = clk_prev & ~clk_sync[2];

    // Bits arrive LSB first, so shift in from the top
    assign next_frame = {data_sync[2], frame[FRAME_BITS-1:1]};
    assign last_bit   = (bit_cnt == CNT_W'(FRAME_BITS - 1));

    assign frame_ok = (next_frame[START_POS] == 1'b0) &&
                      (next_frame[STOP_POS] == 1'b1) &&
                      (^next_frame[PARITY_POS:1] == 1'b1); // Odd parity over data and parity

    always_ff @(posedge clk) begin
        if (fall) begin
            frame <= next_frame;
        end
        if (fall && last_bit) begin
            byte_data <= next_frame[8:1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt     <= '0;
            byte_valid  <= 1'b0;
            overflow    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (fall) begin
                if (last_bit) begin
                    bit_cnt <= '0;
                    if (!frame_ok) begin
                        frame_error <= 1'b1;  // Sticky
                    end else if (scan_full) begin
                        overflow <= 1'b1;     // Byte dropped
                    end else begin
                        byte_valid <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Push was decided on the previous cycle's scan_full
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) byte_valid |-> !scan_full
    ) else $error("byte pushed while scan FIFO is full");

endmodule

/* hdl/sync_fifo.sv */
module sync_fifo #(
    parameter int  DEPTH  = 8,
    parameter type item_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  wr_en,
    input  item_t wr_data,
    input  logic  rd_en,
    output item_t rd_data,
    output logic  full,
    output logic  empty
);

    localparam int AW = $clog2(DEPTH);

    item_t       mem [DEPTH];
    logic [AW:0] wr_ptr;    // Extra bit tells full from empty
    logic [AW:0] rd_ptr;
    logic        do_wr;
    logic        do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Show-ahead head
    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Producers and consumers are expected to honor the flags
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n) wr_en |-> !full
    ) else $error("write while FIFO full");

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (!arst_n) rd_en |-> !empty
    ) else $error("read while FIFO empty");

endmodule

/* hdl/scan_decoder.sv */
module scan_decoder import ps2_pkg::*, key_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       scan_empty,
    input  scan_byte_t scan_data,
    input  logic       event_full,
    output logic       scan_pop,
    output logic       event_push,
    output key_event_t event_data
);

    logic pending_break;  // F0 seen
    logic pending_ext;    // E0 seen
    logic is_break;
    logic is_ext;
    logic is_prefix;

    assign is_break  = (scan_data == BREAK_PREFIX);
    assign is_ext    = (scan_data == EXT_PREFIX);
    assign is_prefix = is_break || is_ext;

    // Pop only when the result has somewhere to go
    assign scan_pop   = !scan_empty && !event_full;
    assign event_push = scan_pop && !is_prefix;

    // Extended codes still go through the same table
    always_comb begin
        event_data.ascii    = scan_to_ascii(scan_data);
        event_data.scan     = scan_data;
        event_data.released = pending_break;
        event_data.extended = pending_ext;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_break <= 1'b0;
            pending_ext   <= 1'b0;
        end else if (scan_pop) begin
            if (is_break) begin
                pending_break <= 1'b1;
            end else if (is_ext) begin
                pending_ext <= 1'b1;
            end else begin
                // Final byte consumed both prefixes
                pending_break <= 1'b0;
                pending_ext   <= 1'b0;
            end
        end
    end

endmodule

/* hdl/credit_tx.sv */
module credit_tx import key_pkg::*; #(
    parameter int CREDITS = 2
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fifo_empty,
    input  key_event_t fifo_data,
    input  logic       credit_return,
    output logic       fifo_pop,
    output logic       event_valid,
    output key_event_t event_data
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credit_cnt;

    assign fifo_pop = !fifo_empty && (credit_cnt != '0);

    // Registered output stage
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            event_data <= fifo_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            event_valid <= 1'b0;
            credit_cnt  <= CW'(CREDITS);
        end else begin
            event_valid <= fifo_pop;
            case ({credit_return, fifo_pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // Both or neither
            endcase
        end
    end

    // A count above CREDITS means the consumer returned an unused credit
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!arst_n) credit_cnt <= CW'(CREDITS)
    ) else $error("credit count above limit, spurious credit_return");

endmodule

/* hdl/ps2_keyboard_top.sv */
module ps2_keyboard_top import ps2_pkg::*, key_pkg::*; #(
    parameter int SCAN_DEPTH  = 8,
    parameter int EVENT_DEPTH = 4,
    parameter int CREDITS     = 2
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       credit_return,
    output logic       event_valid,
    output key_event_t event_data,
    output logic       overflow,
    output logic       frame_error
);

    logic       byte_valid;
    scan_byte_t byte_data;
    logic       scan_full;
    logic       scan_empty;
    scan_byte_t scan_head;
    logic       scan_pop;

    logic       event_push;
    key_event_t event_wdata;
    logic       event_full;
    logic       event_empty;
    key_event_t event_head;
    logic       event_pop;

    ps2_frame_rx rx_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .scan_full   (scan_full),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .overflow    (overflow),
        .frame_error (frame_error)
    );

    sync_fifo #(
        .DEPTH  (SCAN_DEPTH),
        .item_t (scan_byte_t)
    ) scan_fifo_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (byte_valid),
        .wr_data (byte_data),
        .rd_en   (scan_pop),
        .rd_data (scan_head),
        .full    (scan_full),
        .empty   (scan_empty)
    );

    scan_decoder dec_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .scan_empty (scan_empty),
        .scan_data  (scan_head),
        .event_full (event_full),
        .scan_pop   (scan_pop),
        .event_push (event_push),
        .event_data (event_wdata)
    );

    sync_fifo #(
        .DEPTH  (EVENT_DEPTH),
        .item_t (key_event_t)
    ) event_fifo_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_en   (event_push),
        .wr_data (event_wdata),
        .rd_en   (event_pop),
        .rd_data (event_head),
        .full    (event_full),
        .empty   (event_empty)
    );

    credit_tx #(
        .CREDITS (CREDITS)
    ) tx_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fifo_empty    (event_empty),
        .fifo_data     (event_head),
        .credit_return (credit_return),
        .fifo_pop      (event_pop),
        .event_valid   (event_valid),
        .event_data    (event_data)
    );

endmodule

/* bench/ps2_clk_gen.sv */
module ps2_clk_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // Period 10
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;  // Release just after an edge
    end

endmodule

/* bench/keyboard_tb.sv */
module keyboard_tb import ps2_pkg::*, key_pkg::*; ();

    localparam int CREDITS    = 2;
    localparam int HALF       = 20;  // ps2_clk half period in clk cycles
    localparam int N_RAND     = 64;
    // Directed frames plus three frames for each random key at worst
    localparam int MAX_FRAMES = 2 + 44 + 11 + 5 + 3 * N_RAND + 15;
    localparam int LIMIT      = MAX_FRAMES * FRAME_BITS * 2 * HALF + 2000;

    localparam int CR_HOLD   = 0;
    localparam int CR_RANDOM = 1;
    localparam int CR_ALWAYS = 2;

    logic       clk;
    logic       arst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       credit_return = 1'b0;
    logic       event_valid;
    key_event_t event_data;
    logic       overflow;
    logic       frame_error;

    // Set-2 make codes in alphabet and digit order
    logic [7:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
                                      8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31,
                                      8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C,
                                      8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    logic [7:0] digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
                                     8'h3D, 8'h3E, 8'h46};
    logic [7:0] unmapped_codes [8] = '{8'h05, 8'h0D, 8'h29, 8'h5A, 8'h66, 8'h76, 8'h74,
                                       8'h6B};

    integer     seed = 32'h9fa0ed19;
    key_event_t exp_q [$];
    key_event_t exp_ev;
    int         value_errs  = 0;
    int         other_errs  = 0;
    int         seen        = 0;  // Events observed
    int         returned    = 0;  // Credits given back
    int         cycles      = 0;
    int         credit_mode = CR_HOLD;
    int         credit_rate = 1;
    logic       give;

    ps2_clk_gen clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ps2_keyboard_top #(
        .SCAN_DEPTH  (8),
        .EVENT_DEPTH (4),
        .CREDITS     (CREDITS)
    ) dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .credit_return (credit_return),
        .event_valid   (event_valid),
        .event_data    (event_data),
        .overflow      (overflow),
        .frame_error   (frame_error)
    );

    function automatic logic [7:0] ascii_of(input logic [7:0] code);
        logic [7:0] a;
        a = 8'h00;
        for (int i = 0; i < 26; i++) begin
            if (letter_codes[i] == code) a = 8'(65 + i);  // 'A' onward
        end
        for (int i = 0; i < 10; i++) begin
            if (digit_codes[i] == code) a = 8'(48 + i);   // '0' onward
        end
        return a;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Sends one 11-bit frame with data changed while ps2_clk is high
    task automatic send_frame(input logic [7:0] code, input logic flip_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        logic        parity;
        parity = ~^code ^ flip_parity;  // Odd parity
        bits   = {~bad_stop, parity, code, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            ps2_data = bits[i];
            wait_cycles(HALF);
            ps2_clk = 1'b0;
            wait_cycles(HALF);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic send_key(input logic [7:0] code, input logic rel, input logic ext,
                            input logic keep);
        key_event_t ev;
        ev.ascii    = ascii_of(code);
        ev.scan     = code;
        ev.released = rel;
        ev.extended = ext;
        if (ext) send_frame(EXT_PREFIX, 1'b0, 1'b0);
        if (rel) send_frame(BREAK_PREFIX, 1'b0, 1'b0);
        if (keep) exp_q.push_back(ev);  // Event shows up before the frame task returns
        send_frame(code, 1'b0, 1'b0);
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0 || seen != returned) begin
            wait_cycles(1);
        end
        wait_cycles(5);
    endtask

    // Returns credits only while events are outstanding
    always @(posedge clk) begin
        #1;
        give = 1'b0;
        if (arst_n && seen - returned > 0) begin
            if (credit_mode == CR_ALWAYS) begin
                give = 1'b1;
            end else if (credit_mode == CR_RANDOM) begin
                give = ($random(seed) % credit_rate) == 0;
            end
        end
        credit_return = give;
        if (give) returned++;
    end

    always @(negedge clk) begin
        if (arst_n && event_valid) begin
            seen++;
            if (exp_q.size() == 0) begin
                $display("Unexpected event with scan code 0x%h, none was pending",
                         event_data.scan);
                other_errs++;
            end else begin
                exp_ev = exp_q.pop_front();
                compare_value("event_data", 32'(event_data), 32'(exp_ev));
            end
            if (seen - returned > CREDITS) begin
                $display("More events outstanding than credits: %0d sent, %0d returned",
                         seen, returned);
                other_errs++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin : stimulus
        logic [7:0] code;
        int         sel;
        int         pre;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        @(posedge arst_n);
        wait_cycles(2);
        compare_value("event_valid", 32'(event_valid), 32'h0);
        compare_value("overflow", 32'(overflow), 32'h0);
        compare_value("frame_error", 32'(frame_error), 32'h0);

        // Two sends on the reset credits alone
        send_key(8'h1C, 1'b0, 1'b0, 1'b1);
        send_key(8'h16, 1'b0, 1'b0, 1'b1);
        while (seen < 2) wait_cycles(1);
        credit_mode = CR_ALWAYS;
        wait_idle();

        for (int i = 0; i < 26; i++) send_key(letter_codes[i], 1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 10; i++) send_key(digit_codes[i], 1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 8; i++) send_key(unmapped_codes[i], 1'b0, 1'b0, 1'b1);
        wait_idle();

        send_key(8'h1C, 1'b1, 1'b0, 1'b1);
        send_key(8'h75, 1'b0, 1'b1, 1'b1);  // Extended up arrow
        send_key(8'h75, 1'b1, 1'b1, 1'b1);
        send_key(8'h1C, 1'b0, 1'b1, 1'b1);
        send_key(8'h45, 1'b1, 1'b0, 1'b1);
        wait_idle();

        // Bad frames between good ones
        compare_value("frame_error", 32'(frame_error), 32'h0);
        send_key(8'h2B, 1'b0, 1'b0, 1'b1);
        send_frame(8'h33, 1'b1, 1'b0);
        compare_value("frame_error", 32'(frame_error), 32'h1);
        send_key(8'h43, 1'b0, 1'b0, 1'b1);
        send_frame(8'h3B, 1'b0, 1'b1);
        send_key(8'h42, 1'b0, 1'b0, 1'b1);
        wait_idle();

        credit_mode = CR_RANDOM;
        for (int n = 0; n < N_RAND; n++) begin
            if (n % 16 == 0) credit_rate = 1 + $unsigned($random(seed)) % 4;
            sel = $unsigned($random(seed)) % 10;
            if (sel < 6) begin
                code = letter_codes[$unsigned($random(seed)) % 26];
            end else if (sel < 8) begin
                code = digit_codes[$unsigned($random(seed)) % 10];
            end else begin
                code = unmapped_codes[$unsigned($random(seed)) % 8];
            end
            pre = $unsigned($random(seed)) % 4;
            send_key(code, pre[0], pre[1], 1'b1);
        end
        credit_mode = CR_ALWAYS;
        wait_idle();

        // Two sent plus four in the event FIFO and eight in the scan FIFO before the drop
        credit_mode = CR_HOLD;
        for (int i = 0; i < 15; i++) begin
            if (i == 14) compare_value("overflow", 32'(overflow), 32'h0);
            send_key(letter_codes[i], 1'b0, 1'b0, i < 14);
        end
        compare_value("overflow", 32'(overflow), 32'h1);
        credit_mode = CR_ALWAYS;
        wait_idle();
        wait_cycles(100);

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/ps2_pkg.sv
hdl/key_pkg.sv
hdl/ps2_frame_rx.sv
hdl/sync_fifo.sv
hdl/scan_decoder.sv
hdl/credit_tx.sv
hdl/ps2_keyboard_top.sv
bench/ps2_clk_gen.sv
bench/keyboard_tb.sv

/* Makefile */
TOP := keyboard_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(OBJ)
